// ==== tb.f ====
hdl/axi_lite_pkg.sv
hdl/loader_pkg.sv
hdl/axi_lite_slave.sv
hdl/loader_regs.sv
hdl/word_fifo.sv
hdl/entry_assembler.sv
hdl/program_loader.sv
verification/program_loader_asserts.sv
verification/program_loader_tb.sv

// ==== Makefile ====
VERILATOR := verilator
VFLAGS := --binary --timing --assert --timescale 1ns/100ps -Wno-fatal
LINT_FLAGS := --lint-only -Wall --timing --timescale 1ns/100ps
TOP := program_loader_tb
FILE_LIST := tb.f
OBJ_DIR := obj_dir
LOG := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILE_LIST)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q '\*\* FAIL \*\*' $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q '\*\* PASS \*\*' $(LOG); then echo "simulation did not complete"; exit 1; fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILE_LIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== verification/program_loader_tb.sv ====
// ----------------------------------------------------------------------
// program loader testbench
// drives the axi4-lite bus and checks register readback and entries
// ----------------------------------------------------------------------
module program_loader_tb;
    timeunit 1ns;
    timeprecision 100ps;

    // cycles any single wait may take
    localparam int timeout_cycles = 200;

    logic clk;
    logic rst;
    logic [axi_lite_pkg::addr_width-1:0] s_axi_awaddr;
    logic s_axi_awvalid;
    logic s_axi_awready;
    logic [axi_lite_pkg::data_width-1:0] s_axi_wdata;
    logic s_axi_wvalid;
    logic s_axi_wready;
    logic [1:0] s_axi_bresp;
    logic s_axi_bvalid;
    logic s_axi_bready;
    logic [axi_lite_pkg::addr_width-1:0] s_axi_araddr;
    logic s_axi_arvalid;
    logic s_axi_arready;
    logic [axi_lite_pkg::data_width-1:0] s_axi_rdata;
    logic [1:0] s_axi_rresp;
    logic s_axi_rvalid;
    logic s_axi_rready;
    logic [axi_lite_pkg::data_width-1:0] memory_addr;
    logic [loader_pkg::entry_width-1:0] memory_data;
    logic memory_we;
    logic done;

    integer seed;
    logic [31:0] words [12];
    logic [31:0] rd;
    logic [31:0] addr_value;
    // memory writes seen so far and the last entry written
    int we_count;
    logic [loader_pkg::entry_width-1:0] last_entry;
    int error_count;
    int errors_at_start;
    int test_count;
    int failed_tests;

    program_loader u_program_loader
    (
        .clk           (clk),
        .rst           (rst),
        .s_axi_awaddr  (s_axi_awaddr),
        .s_axi_awvalid (s_axi_awvalid),
        .s_axi_awready (s_axi_awready),
        .s_axi_wdata   (s_axi_wdata),
        .s_axi_wvalid  (s_axi_wvalid),
        .s_axi_wready  (s_axi_wready),
        .s_axi_bresp   (s_axi_bresp),
        .s_axi_bvalid  (s_axi_bvalid),
        .s_axi_bready  (s_axi_bready),
        .s_axi_araddr  (s_axi_araddr),
        .s_axi_arvalid (s_axi_arvalid),
        .s_axi_arready (s_axi_arready),
        .s_axi_rdata   (s_axi_rdata),
        .s_axi_rresp   (s_axi_rresp),
        .s_axi_rvalid  (s_axi_rvalid),
        .s_axi_rready  (s_axi_rready),
        .memory_addr   (memory_addr),
        .memory_data   (memory_data),
        .memory_we     (memory_we),
        .done          (done)
    );

    bind program_loader program_loader_asserts u_program_loader_asserts
    (
        .clk           (clk),
        .rst           (rst),
        .s_axi_awready (s_axi_awready),
        .s_axi_bvalid  (s_axi_bvalid),
        .s_axi_bready  (s_axi_bready),
        .s_axi_rvalid  (s_axi_rvalid),
        .s_axi_rready  (s_axi_rready),
        .s_axi_rdata   (s_axi_rdata),
        .memory_we     (memory_we),
        .done          (done)
    );

    // 8 ns clock
    initial
    begin
        clk = 1'b0;
        forever
        begin
            #4 clk = ~clk;
        end
    end

    // memory_we is a single cycle pulse, catch it mid cycle
    always @(negedge clk)
    begin
        if (!rst && memory_we)
        begin
            we_count = we_count + 1;
            last_entry = memory_data;
        end
    end

    // inputs change 1 ns after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    function automatic logic [axi_lite_pkg::addr_width-1:0] reg_byte_addr(
        input logic [axi_lite_pkg::reg_index_width-1:0] index);
        logic [axi_lite_pkg::addr_width-1:0] addr;
        addr = '0;
        addr[axi_lite_pkg::reg_addr_lsb +: axi_lite_pkg::reg_index_width] = index;
        return addr;
    endfunction

    // first pushed word lands in the top 32 bits
    function automatic logic [loader_pkg::entry_width-1:0] expected_entry(input int first);
        return {words[first], words[first + 1], words[first + 2], words[first + 3]};
    endfunction

    task automatic check_value(input string name, input logic [127:0] expected,
                               input logic [127:0] actual);
        assert (actual === expected)
        else
        begin
            $display("Fail %s: expected %0h, actual %0h", name, expected, actual);
            error_count++;
        end
    endtask

    task automatic axi_write(input logic [axi_lite_pkg::reg_index_width-1:0] index,
                             input logic [31:0] data);
        int cycles;
        logic aw_seen;
        logic w_seen;
        cycles = 0;
        s_axi_awaddr = reg_byte_addr(index);
        s_axi_wdata = data;
        s_axi_awvalid = 1'b1;
        s_axi_wvalid = 1'b1;
        next_cycle();
        // both ready signals pulse while the write is pending
        aw_seen = s_axi_awready;
        w_seen = s_axi_wready;
        while (!s_axi_bvalid && cycles < timeout_cycles)
        begin
            next_cycle();
            cycles++;
            aw_seen = aw_seen | s_axi_awready;
            w_seen = w_seen | s_axi_wready;
        end
        s_axi_awvalid = 1'b0;
        s_axi_wvalid = 1'b0;
        if (!s_axi_bvalid)
        begin
            $display("timeout: no write response for register %0d", index);
            error_count++;
        end
        else
        begin
            check_value("write response", 2'b00, s_axi_bresp);
            check_value("write awready", 1'b1, aw_seen);
            check_value("write wready", 1'b1, w_seen);
            // leave bready low for a cycle so the response has to wait
            next_cycle();
            s_axi_bready = 1'b1;
            next_cycle();
            s_axi_bready = 1'b0;
        end
    endtask

    task automatic axi_read(input logic [axi_lite_pkg::reg_index_width-1:0] index,
                            output logic [31:0] data);
        int cycles;
        logic ar_seen;
        cycles = 0;
        data = '0;
        s_axi_araddr = reg_byte_addr(index);
        s_axi_arvalid = 1'b1;
        next_cycle();
        ar_seen = s_axi_arready;
        while (!s_axi_rvalid && cycles < timeout_cycles)
        begin
            next_cycle();
            cycles++;
            ar_seen = ar_seen | s_axi_arready;
        end
        s_axi_arvalid = 1'b0;
        if (!s_axi_rvalid)
        begin
            $display("timeout: no read data for register %0d", index);
            error_count++;
        end
        else
        begin
            data = s_axi_rdata;
            check_value("read response", 2'b00, s_axi_rresp);
            check_value("read arready", 1'b1, ar_seen);
            // one cycle of back-pressure on the read data
            next_cycle();
            s_axi_rready = 1'b1;
            next_cycle();
            s_axi_rready = 1'b0;
        end
    endtask

    task automatic wait_entries(input int target);
        int cycles;
        cycles = 0;
        while (we_count < target && cycles < timeout_cycles)
        begin
            next_cycle();
            cycles++;
        end
        if (we_count < target)
        begin
            $display("timeout: memory write number %0d never happened", target);
            error_count++;
        end
    endtask

    // polls the empty flag over the bus
    task automatic wait_fifo_empty();
        logic [31:0] value;
        int tries;
        value = '0;
        tries = 0;
        while (value[0] !== 1'b1 && tries < timeout_cycles)
        begin
            axi_read(loader_pkg::off_empty, value);
            tries++;
        end
        if (value[0] !== 1'b1)
        begin
            $display("timeout: word fifo never reported empty");
            error_count++;
        end
    endtask

    task automatic wait_done();
        int cycles;
        cycles = 0;
        while (done !== 1'b1 && cycles < timeout_cycles)
        begin
            next_cycle();
            cycles++;
        end
        if (done !== 1'b1)
        begin
            $display("timeout: done never rose");
            error_count++;
        end
    endtask

    task automatic end_test(input string name);
        test_count++;
        if (error_count == errors_at_start)
        begin
            $display("test %s: ok", name);
        end
        else
        begin
            failed_tests++;
            $display("test %s: %0d errors", name, error_count - errors_at_start);
        end
        errors_at_start = error_count;
    endtask

    initial
    begin
        rst = 1'b1;
        s_axi_awaddr = '0;
        s_axi_awvalid = 1'b0;
        s_axi_wdata = '0;
        s_axi_wvalid = 1'b0;
        s_axi_bready = 1'b0;
        s_axi_araddr = '0;
        s_axi_arvalid = 1'b0;
        s_axi_rready = 1'b0;
        we_count = 0;
        last_entry = '0;
        error_count = 0;
        errors_at_start = 0;
        test_count = 0;
        failed_tests = 0;
        seed = 32'h9ce94ee4;
        for (int i = 0; i < 12; i++)
        begin
            words[i] = $random(seed);
        end
        addr_value = $random(seed);

        repeat (16) @(posedge clk);
        #1 rst = 1'b0;
        next_cycle();

        // reset values of the stored and live registers
        axi_read(loader_pkg::off_prog_size, rd);
        check_value("reset prog_size", 32'hffff_ffff, rd);
        axi_read(loader_pkg::off_empty, rd);
        check_value("reset empty", 32'd1, rd);
        axi_read(loader_pkg::off_full, rd);
        check_value("reset full", 32'd0, rd);
        axi_read(loader_pkg::off_entry_count, rd);
        check_value("reset entry_count", 32'd0, rd);
        axi_read(loader_pkg::off_popped_count, rd);
        check_value("reset popped_count", 32'd0, rd);
        check_value("reset done", 1'b0, done);
        end_test("reset values");

        axi_write(loader_pkg::off_mem_addr, addr_value);
        axi_read(loader_pkg::off_mem_addr, rd);
        check_value("mem_addr readback", addr_value, rd);
        check_value("memory_addr output", addr_value, memory_addr);
        end_test("register readback");

        // four pushes make one entry
        for (int i = 0; i < 4; i++)
        begin
            axi_write(loader_pkg::off_push, words[i]);
        end
        wait_entries(1);
        check_value("first entry", expected_entry(0), last_entry);
        axi_read(loader_pkg::off_entry_count, rd);
        check_value("entry_count after one entry", 32'd1, rd);
        end_test("entry assembly");

        wait_fifo_empty();
        axi_write(loader_pkg::off_push, words[4]);
        axi_write(loader_pkg::off_push, words[5]);
        wait_fifo_empty();
        axi_read(loader_pkg::off_popped_count, rd);
        check_value("popped_count", 32'd2, rd);
        check_value("memory writes after partial entry", 32'd1, we_count);
        end_test("popped count");

        // finish the pending entry, then one more to reach three
        axi_write(loader_pkg::off_prog_size, 32'd3);
        axi_write(loader_pkg::off_push, words[6]);
        axi_write(loader_pkg::off_push, words[7]);
        wait_entries(2);
        check_value("second entry", expected_entry(4), last_entry);
        wait_fifo_empty();
        axi_read(loader_pkg::off_entry_count, rd);
        check_value("entry_count after two entries", 32'd2, rd);
        check_value("done with two entries", 1'b0, done);
        for (int i = 8; i < 12; i++)
        begin
            axi_write(loader_pkg::off_push, words[i]);
        end
        wait_entries(3);
        check_value("third entry", expected_entry(8), last_entry);
        wait_done();
        end_test("done rule");

        $display("tests run %0d, tests failed %0d, failed checks %0d",
                 test_count, failed_tests, error_count);
        if (error_count == 0)
        begin
            $display("** PASS **");
        end
        else
        begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// ==== verification/program_loader_asserts.sv ====
// ----------------------------------------------------------------------
// program loader checks
// bus response holding and single cycle pulses, bound to the top
// ----------------------------------------------------------------------
module program_loader_asserts
(
    input logic clk,
    input logic rst,
    input logic s_axi_awready,
    input logic s_axi_bvalid,
    input logic s_axi_bready,
    input logic s_axi_rvalid,
    input logic s_axi_rready,
    input logic [axi_lite_pkg::data_width-1:0] s_axi_rdata,
    input logic memory_we,
    input logic done
);
    timeunit 1ns;
    timeprecision 100ps;

    // write response stays up until the master takes it
    bvalid_held: assert property (@(posedge clk) disable iff (rst)
        s_axi_bvalid && !s_axi_bready |=> s_axi_bvalid)
        else $error("bvalid dropped before bready");

    // read data and valid frozen under back-pressure
    rvalid_held: assert property (@(posedge clk) disable iff (rst)
        s_axi_rvalid && !s_axi_rready |=> s_axi_rvalid && $stable(s_axi_rdata))
        else $error("rvalid or rdata changed before rready");

    // one cycle pulses
    awready_pulse: assert property (@(posedge clk) disable iff (rst)
        s_axi_awready |=> !s_axi_awready)
        else $error("awready high for more than one cycle");

    memory_we_pulse: assert property (@(posedge clk) disable iff (rst)
        memory_we |=> !memory_we)
        else $error("memory_we high for more than one cycle");

    // done is sticky until reset
    done_sticky: assert property (@(posedge clk) disable iff (rst)
        done |=> done)
        else $error("done fell outside reset");

endmodule

// ==== hdl/program_loader.sv ====
// --------------------------------------------------------------------
// program loader top
// axi4-lite registers feeding a word fifo and an entry assembler
// --------------------------------------------------------------------
module program_loader
(
    input  logic clk,
    input  logic rst,
    input  logic [axi_lite_pkg::addr_width-1:0] s_axi_awaddr,
    input  logic s_axi_awvalid,
    output logic s_axi_awready,
    input  logic [axi_lite_pkg::data_width-1:0] s_axi_wdata,
    input  logic s_axi_wvalid,
    output logic s_axi_wready,
    output logic [1:0] s_axi_bresp,
    output logic s_axi_bvalid,
    input  logic s_axi_bready,
    input  logic [axi_lite_pkg::addr_width-1:0] s_axi_araddr,
    input  logic s_axi_arvalid,
    output logic s_axi_arready,
    output logic [axi_lite_pkg::data_width-1:0] s_axi_rdata,
    output logic [1:0] s_axi_rresp,
    output logic s_axi_rvalid,
    input  logic s_axi_rready,
    output logic [axi_lite_pkg::data_width-1:0] memory_addr,
    output logic [loader_pkg::entry_width-1:0] memory_data,
    output logic memory_we,
    output logic done
);

    // slave to register block
    logic reg_wr;
    logic [axi_lite_pkg::reg_index_width-1:0] reg_wr_index;
    logic [axi_lite_pkg::data_width-1:0] reg_wr_data;
    // read strobe and index, read data comes back combinationally
    logic reg_rd;
    logic [axi_lite_pkg::reg_index_width-1:0] reg_rd_index;
    logic [axi_lite_pkg::data_width-1:0] reg_rd_data;

    // fifo and assembler
    logic push;
    logic [axi_lite_pkg::data_width-1:0] push_data;
    logic pop;
    logic [loader_pkg::word_width-1:0] head_data;
    logic full;
    logic empty;
    logic [axi_lite_pkg::data_width-1:0] entry_count;
    logic [loader_pkg::word_count_width-1:0] popped_count;
    logic [axi_lite_pkg::data_width-1:0] prog_size;

    axi_lite_slave u_axi_lite_slave
    (
        .clk           (clk),
        .rst           (rst),
        .s_axi_awaddr  (s_axi_awaddr),
        .s_axi_awvalid (s_axi_awvalid),
        .s_axi_awready (s_axi_awready),
        .s_axi_wdata   (s_axi_wdata),
        .s_axi_wvalid  (s_axi_wvalid),
        .s_axi_wready  (s_axi_wready),
        .s_axi_bresp   (s_axi_bresp),
        .s_axi_bvalid  (s_axi_bvalid),
        .s_axi_bready  (s_axi_bready),
        .s_axi_araddr  (s_axi_araddr),
        .s_axi_arvalid (s_axi_arvalid),
        .s_axi_arready (s_axi_arready),
        .s_axi_rdata   (s_axi_rdata),
        .s_axi_rresp   (s_axi_rresp),
        .s_axi_rvalid  (s_axi_rvalid),
        .s_axi_rready  (s_axi_rready),
        .reg_wr        (reg_wr),
        .reg_wr_index  (reg_wr_index),
        .reg_wr_data   (reg_wr_data),
        .reg_rd        (reg_rd),
        .reg_rd_index  (reg_rd_index),
        .reg_rd_data   (reg_rd_data)
    );

    loader_regs u_loader_regs
    (
        .clk          (clk),
        .rst          (rst),
        .reg_wr       (reg_wr),
        .reg_wr_index (reg_wr_index),
        .reg_wr_data  (reg_wr_data),
        .reg_rd_index (reg_rd_index),
        .reg_rd_data  (reg_rd_data),
        .push         (push),
        .push_data    (push_data),
        .full         (full),
        .empty        (empty),
        .entry_count  (entry_count),
        .popped_count (popped_count),
        .memory_addr  (memory_addr),
        .prog_size    (prog_size)
    );

    word_fifo u_word_fifo
    (
        .clk       (clk),
        .rst       (rst),
        .push      (push),
        .push_data (push_data),
        .pop       (pop),
        .head_data (head_data),
        .full      (full),
        .empty     (empty)
    );

    entry_assembler u_entry_assembler
    (
        .clk          (clk),
        .rst          (rst),
        .empty        (empty),
        .head_data    (head_data),
        .prog_size    (prog_size),
        .pop          (pop),
        .memory_data  (memory_data),
        .memory_we    (memory_we),
        .entry_count  (entry_count),
        .popped_count (popped_count),
        .done         (done)
    );

endmodule

// ==== hdl/entry_assembler.sv ====
// --------------------------------------------------------------------
// memory entry assembler
// packs four words per entry, writes it out and tracks done
// --------------------------------------------------------------------
module entry_assembler
(
    input  logic clk,
    input  logic rst,
    input  logic empty,
    input  logic [loader_pkg::word_width-1:0] head_data,
    input  logic [loader_pkg::word_width-1:0] prog_size,
    output logic pop,
    output logic [loader_pkg::entry_width-1:0] memory_data,
    output logic memory_we,
    output logic [loader_pkg::word_width-1:0] entry_count,
    output logic [loader_pkg::word_count_width-1:0] popped_count,
    output logic done
);

    logic last_word;

    // drain one word every cycle the fifo has one
    assign pop = ~empty;
    assign last_word = pop && (popped_count == loader_pkg::words_per_entry - 1);

    // shift in at the low end, first word ends up on top
    always_ff @(posedge clk)
    begin
        if (pop)
        begin
            memory_data <= {memory_data[loader_pkg::entry_width-loader_pkg::word_width-1:0],
                            head_data};
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            popped_count <= '0;
        end
        else if (last_word)
        begin
            popped_count <= '0;
        end
        else if (pop)
        begin
            popped_count <= popped_count + 1'b1;
        end
    end

    // write pulse and entry count follow the fourth pop
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            memory_we <= 1'b0;
            entry_count <= '0;
        end
        else
        begin
            memory_we <= last_word;
            if (last_word)
            begin
                entry_count <= entry_count + 1'b1;
            end
        end
    end

    // sticky until reset
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            done <= 1'b0;
        end
        else if (entry_count >= prog_size)
        begin
            done <= 1'b1;
        end
    end

endmodule

// ==== hdl/word_fifo.sv ====
// --------------------------------------------------------------------
// word fifo
// holds pushed words until the assembler takes them
// --------------------------------------------------------------------
module word_fifo
(
    input  logic clk,
    input  logic rst,
    input  logic push,
    input  logic [loader_pkg::word_width-1:0] push_data,
    input  logic pop,
    output logic [loader_pkg::word_width-1:0] head_data,
    output logic full,
    output logic empty
);

    logic [loader_pkg::word_width-1:0] mem [loader_pkg::fifo_depth];
    logic [loader_pkg::fifo_ptr_width-1:0] wr_ptr;
    logic [loader_pkg::fifo_ptr_width-1:0] rd_ptr;
    logic [loader_pkg::fifo_count_width-1:0] count;
    logic do_push;
    logic do_pop;

    // drop a push when full, ignore a pop when empty
    assign do_push = push & ~full;
    assign do_pop = pop & ~empty;

    always_ff @(posedge clk)
    begin
        if (do_push)
        begin
            mem[wr_ptr] <= push_data;
        end
    end

    // pointers wrap on their own, depth is a power of two
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end
        else
        begin
            if (do_push)
            begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop)
            begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + do_push - do_pop;
        end
    end

    assign head_data = mem[rd_ptr];
    assign full = (count == loader_pkg::fifo_depth);
    assign empty = (count == 0);

endmodule

// ==== hdl/loader_regs.sv ====
// --------------------------------------------------------------------
// loader control registers
// register array, push decode and readback of live status
// --------------------------------------------------------------------
module loader_regs
(
    input  logic clk,
    input  logic rst,
    input  logic reg_wr,
    input  logic [axi_lite_pkg::reg_index_width-1:0] reg_wr_index,
    input  logic [axi_lite_pkg::data_width-1:0] reg_wr_data,
    input  logic [axi_lite_pkg::reg_index_width-1:0] reg_rd_index,
    output logic [axi_lite_pkg::data_width-1:0] reg_rd_data,
    output logic push,
    output logic [axi_lite_pkg::data_width-1:0] push_data,
    input  logic full,
    input  logic empty,
    input  logic [axi_lite_pkg::data_width-1:0] entry_count,
    input  logic [loader_pkg::word_count_width-1:0] popped_count,
    output logic [axi_lite_pkg::data_width-1:0] memory_addr,
    output logic [axi_lite_pkg::data_width-1:0] prog_size
);

    logic [axi_lite_pkg::data_width-1:0] regs [axi_lite_pkg::reg_count];

    // every write lands in the array, strobes are ignored
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int i = 0; i < axi_lite_pkg::reg_count; i++)
            begin
                if (i == int'(loader_pkg::off_prog_size))
                begin
                    regs[i] <= loader_pkg::prog_size_reset;
                end
                else
                begin
                    regs[i] <= '0;
                end
            end
        end
        else if (reg_wr)
        begin
            regs[reg_wr_index] <= reg_wr_data;
        end
    end

    // push trails the write strobe by one cycle
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            push <= 1'b0;
        end
        else
        begin
            push <= reg_wr && (reg_wr_index == loader_pkg::off_push);
        end
    end

    always_ff @(posedge clk)
    begin
        push_data <= reg_wr_data;
    end

    // live status at four offsets, stored values elsewhere
    always_comb
    begin
        case (reg_rd_index)
            loader_pkg::off_full:
                reg_rd_data = {{(axi_lite_pkg::data_width - 1){1'b0}}, full};
            loader_pkg::off_entry_count:
                reg_rd_data = entry_count;
            loader_pkg::off_empty:
                reg_rd_data = {{(axi_lite_pkg::data_width - 1){1'b0}}, empty};
            loader_pkg::off_popped_count:
                reg_rd_data = {{(axi_lite_pkg::data_width - loader_pkg::word_count_width){1'b0}},
                               popped_count};
            default:
                reg_rd_data = regs[reg_rd_index];
        endcase
    end

    assign memory_addr = regs[loader_pkg::off_mem_addr];
    assign prog_size = regs[loader_pkg::off_prog_size];

endmodule

// ==== hdl/axi_lite_slave.sv ====
// --------------------------------------------------------------------
// axi4-lite slave front end
// turns bus transfers into register write and read strobes
// --------------------------------------------------------------------
module axi_lite_slave
(
    input  logic clk,
    input  logic rst,
    input  logic [axi_lite_pkg::addr_width-1:0] s_axi_awaddr,
    input  logic s_axi_awvalid,
    output logic s_axi_awready,
    input  logic [axi_lite_pkg::data_width-1:0] s_axi_wdata,
    input  logic s_axi_wvalid,
    output logic s_axi_wready,
    output logic [1:0] s_axi_bresp,
    output logic s_axi_bvalid,
    input  logic s_axi_bready,
    input  logic [axi_lite_pkg::addr_width-1:0] s_axi_araddr,
    input  logic s_axi_arvalid,
    output logic s_axi_arready,
    output logic [axi_lite_pkg::data_width-1:0] s_axi_rdata,
    output logic [1:0] s_axi_rresp,
    output logic s_axi_rvalid,
    input  logic s_axi_rready,
    output logic reg_wr,
    output logic [axi_lite_pkg::reg_index_width-1:0] reg_wr_index,
    output logic [axi_lite_pkg::data_width-1:0] reg_wr_data,
    output logic reg_rd,
    output logic [axi_lite_pkg::reg_index_width-1:0] reg_rd_index,
    input  logic [axi_lite_pkg::data_width-1:0] reg_rd_data
);

    // low while a write response is still outstanding
    logic aw_en;
    logic wr_accept;
    logic rd_accept;

    // take a write only with address and data both present
    assign wr_accept = ~s_axi_awready & s_axi_awvalid & s_axi_wvalid & aw_en;

    // no new read while a read response waits for rready
    assign rd_accept = ~s_axi_arready & s_axi_arvalid & ~s_axi_rvalid;

    // awready and wready pulse together for one cycle
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            s_axi_awready <= 1'b0;
            s_axi_wready <= 1'b0;
            aw_en <= 1'b1;
        end
        else if (wr_accept)
        begin
            s_axi_awready <= 1'b1;
            s_axi_wready <= 1'b1;
            aw_en <= 1'b0;
        end
        else
        begin
            s_axi_awready <= 1'b0;
            s_axi_wready <= 1'b0;
            // response taken, ready for the next write
            if (s_axi_bvalid && s_axi_bready)
            begin
                aw_en <= 1'b1;
            end
        end
    end

    // keep only the register index bits of the write address
    always_ff @(posedge clk)
    begin
        if (wr_accept)
        begin
            reg_wr_index <= s_axi_awaddr[axi_lite_pkg::reg_addr_lsb +:
                                         axi_lite_pkg::reg_index_width];
        end
    end

    // strobe in the cycle both ready signals are up
    assign reg_wr = s_axi_awready & s_axi_awvalid & s_axi_wready & s_axi_wvalid;
    assign reg_wr_data = s_axi_wdata;

    // write response, held until bready
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            s_axi_bvalid <= 1'b0;
        end
        else if (reg_wr && !s_axi_bvalid)
        begin
            s_axi_bvalid <= 1'b1;
        end
        else if (s_axi_bready && s_axi_bvalid)
        begin
            s_axi_bvalid <= 1'b0;
        end
    end

    assign s_axi_bresp = axi_lite_pkg::resp_okay;

    // arready is a single cycle pulse
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            s_axi_arready <= 1'b0;
        end
        else
        begin
            s_axi_arready <= rd_accept;
        end
    end

    always_ff @(posedge clk)
    begin
        if (rd_accept)
        begin
            reg_rd_index <= s_axi_araddr[axi_lite_pkg::reg_addr_lsb +:
                                         axi_lite_pkg::reg_index_width];
        end
    end

    assign reg_rd = s_axi_arready & s_axi_arvalid & ~s_axi_rvalid;

    // read data valid, held with its data until rready
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            s_axi_rvalid <= 1'b0;
        end
        else if (reg_rd)
        begin
            s_axi_rvalid <= 1'b1;
        end
        else if (s_axi_rvalid && s_axi_rready)
        begin
            s_axi_rvalid <= 1'b0;
        end
    end

    // sample the register mux on the read strobe only
    always_ff @(posedge clk)
    begin
        if (reg_rd)
        begin
            s_axi_rdata <= reg_rd_data;
        end
    end

    assign s_axi_rresp = axi_lite_pkg::resp_okay;

endmodule

// ==== hdl/loader_pkg.sv ====
// --------------------------------------------------------------------
// program loader definitions
// register map, memory entry geometry and fifo sizing
// --------------------------------------------------------------------
package loader_pkg;

    // one memory entry holds four bus words
    localparam int entry_width = 128;
    localparam int words_per_entry = 4;
    localparam int word_width = entry_width / words_per_entry;

    // counts the words already taken into the current entry
    localparam int word_count_width = 2;

    // word fifo between the register block and the assembler
    localparam int fifo_depth = 4;
    localparam int fifo_ptr_width = 2;
    // one more bit so a full fifo can be told from an empty one
    localparam int fifo_count_width = 3;

    // register offsets in words
    // reads at index 0 return full, writes at index 0 push a word
    localparam logic [axi_lite_pkg::reg_index_width-1:0] off_full = 3'd0;
    localparam logic [axi_lite_pkg::reg_index_width-1:0] off_push = 3'd0;
    localparam logic [axi_lite_pkg::reg_index_width-1:0] off_mem_addr = 3'd1;
    localparam logic [axi_lite_pkg::reg_index_width-1:0] off_prog_size = 3'd2;
    localparam logic [axi_lite_pkg::reg_index_width-1:0] off_entry_count = 3'd3;
    localparam logic [axi_lite_pkg::reg_index_width-1:0] off_empty = 3'd4;
    localparam logic [axi_lite_pkg::reg_index_width-1:0] off_popped_count = 3'd5;

    // program size starts at its largest value so done stays low
    localparam logic [word_width-1:0] prog_size_reset = '1;

endpackage

// ==== hdl/axi_lite_pkg.sv ====
// --------------------------------------------------------------------
// axi4-lite slave definitions
// bus widths, register index geometry and response codes
// --------------------------------------------------------------------
package axi_lite_pkg;

    // byte address width on the bus
    localparam int addr_width = 32;

    // data width of the bus and of every register
    localparam int data_width = 32;

    // lowest byte address bit that picks a register (one word each)
    localparam int reg_addr_lsb = 2;

    // register index taken from the address
    localparam int reg_index_width = 3;
    localparam int reg_count = 8;

    // okay response, no error responses are generated
    localparam logic [1:0] resp_okay = 2'b00;

endpackage
